// ==== filelist.f ====
design/ln_fixed_pkg.sv
design/ln_ctrl_pkg.sv
design/ln_row_buffer.sv
design/ln_mean_accum.sv
design/ln_variance_unit.sv
design/ln_isqrt_lut.sv
design/ln_normalize.sv
design/layer_norm_top.sv
bench/ln_assert.sv
bench/tb_layer_norm.sv

// ==== Bender.yml ====
package:
  name: layer_norm

sources:
  - files:
      - design/ln_fixed_pkg.sv
      - design/ln_ctrl_pkg.sv
      - design/ln_row_buffer.sv
      - design/ln_mean_accum.sv
      - design/ln_variance_unit.sv
      - design/ln_isqrt_lut.sv
      - design/ln_normalize.sv
      - design/layer_norm_top.sv
  - target: test
    files:
      - bench/ln_assert.sv
      - bench/tb_layer_norm.sv

// ==== bench/tb_layer_norm.sv ====
// Testbench for layer_norm_top with stimulus, reference model and output checking
`timescale 1ns/1ps
`default_nettype none

module tb_layer_norm;

  import ln_fixed_pkg::*;

  localparam int LANES        = 2;
  localparam int ROW_SIZE     = 8;
  localparam int BEATS        = ROW_SIZE / LANES;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  localparam int TIMEOUT      = 2000;
  localparam int SEED         = 62859;
  localparam int READY_ON     = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_OFF    = 2;

  logic                         clk;
  logic                         arst_n;
  logic [LANES*IN_WIDTH-1:0]    in_data;
  logic                         in_valid;
  logic                         in_ready;
  logic [LANES*OUT_WIDTH-1:0]   out_data;
  logic                         out_valid;
  logic                         out_ready;
  int                           ready_mode;
  logic [LANES*OUT_WIDTH-1:0]   exp_q [$];

  layer_norm_top #(.LANES(LANES), .ROW_SIZE(ROW_SIZE)) DUT (
    .clk(clk), .arst_n(arst_n),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Largest r with r*r*v <= 16*16*16, i.e. floor(16*sqrt(16/v))
  function automatic int inv_root_q4(input int v);
    int r;
    if (v == 0) begin
      return 255;
    end
    r = 0;
    while ((r + 1) * (r + 1) * v <= 16 * 16 * 16) begin
      r++;
    end
    return (r > 255) ? 255 : r;
  endfunction

  task automatic model_row(input int x [ROW_SIZE]);
    int sum;
    int mean;
    int sq_sum;
    int idx;
    int root;
    int y;
    logic [LANES*OUT_WIDTH-1:0] beat;
    sum = 0;
    sq_sum = 0;
    foreach (x[i]) sum += x[i];
    mean = sum >>> $clog2(ROW_SIZE);
    foreach (x[i]) sq_sum += (x[i] - mean) * (x[i] - mean);
    // Variance keeps 2*IN_FRAC fraction bits, index keeps ISQRT_FRAC
    idx = (sq_sum >>> $clog2(ROW_SIZE)) >>> (2 * IN_FRAC - ISQRT_FRAC);
    idx = (idx > 255) ? 255 : idx;
    root = inv_root_q4(idx);
    for (int b = 0; b < BEATS; b++) begin
      for (int i = 0; i < LANES; i++) begin
        y = ((x[b*LANES+i] - mean) * root) >>> (IN_FRAC + ISQRT_FRAC - OUT_FRAC);
        if (y > (1 << (OUT_WIDTH - 1)) - 1) y = (1 << (OUT_WIDTH - 1)) - 1;
        if (y < -(1 << (OUT_WIDTH - 1))) y = -(1 << (OUT_WIDTH - 1));
        beat[i*OUT_WIDTH +: OUT_WIDTH] = OUT_WIDTH'(y);
      end
      exp_q.push_back(beat);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
  task automatic send_beat(input logic [LANES*IN_WIDTH-1:0] beat);
    int waited;
    waited = 0;
    in_data  = beat;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT) fail_stop("Input beat was not accepted before the timeout");
      else @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_row(input int x [ROW_SIZE]);
    logic [LANES*IN_WIDTH-1:0] beat;
    model_row(x);
    for (int b = 0; b < BEATS; b++) begin
      for (int i = 0; i < LANES; i++) begin
        beat[i*IN_WIDTH +: IN_WIDTH] = IN_WIDTH'(x[b*LANES+i]);
      end
      send_beat(beat);
    end
  endtask

  task automatic random_row(output int x [ROW_SIZE]);
    foreach (x[i]) x[i] = int'(elem_t'($urandom));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) fail_stop("Expected output beats did not arrive before the timeout");
      else @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Input stays blocked for 16 cycles in a row once all buffers are full
  task automatic wait_input_stall();
    int waited;
    int blocked;
    waited = 0;
    blocked = 0;
    while (blocked < 16) begin
      @(negedge clk);
      blocked = (in_valid && !in_ready) ? blocked + 1 : 0;
      waited++;
      if (waited > TIMEOUT) fail_stop("in_ready never dropped while out_ready was held low");
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #1;
      case (ready_mode)
        READY_OFF:    out_ready = 1'b0;
        READY_RANDOM: out_ready = 1'($urandom);
        default:      out_ready = 1'b1;
      endcase
    end
  end

  // Outputs sampled mid-cycle, a transfer follows at the next rising edge
  initial begin : monitor
    logic [LANES*OUT_WIDTH-1:0] exp;
    forever begin
      @(negedge clk);
      if (DUT.u_assert.error_count != 0) begin
        fail_stop("A protocol assertion in ln_assert failed");
      end else if (arst_n && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          fail_stop("Output beat appeared with no expected beat pending");
        end else begin
          exp = exp_q.pop_front();
          assert (out_data === exp)
            else fail_stop($sformatf("Mismatch at %0t: out_data expected %h, got %h",
                                     $time, exp, out_data));
        end
      end
    end
  end

  initial begin : stimulus
    int row [ROW_SIZE];
    in_data    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    arst_n     = 1'b1;
    ready_mode = READY_OFF;
    void'($urandom(SEED));
    #1;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    ready_mode = READY_ON;
    @(negedge clk);
    assert (out_valid === 1'b0)
      else fail_stop($sformatf("Mismatch at %0t: out_valid expected 0, got %b", $time, out_valid));
    assert (in_ready === 1'b1)
      else fail_stop($sformatf("Mismatch at %0t: in_ready expected 1, got %b", $time, in_ready));
    @(posedge clk);
    #1;

    // Flat row, zero variance
    foreach (row[i]) row[i] = 19;
    send_row(row);
    drain();

    repeat (20) begin
      random_row(row);
      send_row(row);
    end
    drain();

    // Small variance maps to index 0, so the outlier lands past the output range
    row = '{2, 2, 1, 1, 1, 1, 1, -9};
    send_row(row);
    row = '{-2, -2, -1, -1, -1, -1, -1, 9};
    send_row(row);
    drain();

    ready_mode = READY_RANDOM;
    repeat (10) begin
      random_row(row);
      send_row(row);
    end
    drain();

    ready_mode = READY_OFF;
    fork
      begin
        repeat (12) begin
          random_row(row);
          send_row(row);
        end
      end
      begin
        wait_input_stall();
        ready_mode = READY_RANDOM;
      end
    join
    drain();

    // Quiet period catches any extra output beat
    repeat (20) @(negedge clk);
    if (DUT.u_assert.error_count == 0 && exp_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_stop("Run ended with pending beats or failed protocol assertions");
    end
  end

endmodule

`default_nettype wire

// ==== bench/ln_assert.sv ====
// Handshake protocol assertions for layer_norm_top and their bind statement
`timescale 1ns/1ps
`default_nettype none

module ln_assert #(
  parameter int LANES = 2
) (
  input logic                                    clk,
  input logic                                    arst_n,
  input logic                                    in_ready,
  input logic [LANES*ln_fixed_pkg::OUT_WIDTH-1:0] out_data,
  input logic                                    out_valid,
  input logic                                    out_ready
);

  int unsigned error_count = 0;

  // No output while reset is applied
  out_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      error_count++;
      $error("out_valid high while reset is asserted");
    end

  // First edge after release
  out_idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid)
    else begin
      error_count++;
      $error("out_valid high right after reset release");
    end

  in_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> in_ready)
    else begin
      error_count++;
      $error("in_ready low right after reset release");
    end

  out_held_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
      error_count++;
      $error("Output beat changed or dropped while out_ready was low");
    end

endmodule

bind layer_norm_top ln_assert #(.LANES(LANES)) u_assert (
  .clk(clk), .arst_n(arst_n),
  .in_ready(in_ready),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
);

`default_nettype wire

// ==== design/layer_norm_top.sv ====
// Layer-normalization top level with input split and lane packing
`timescale 1ns/1ps
`default_nettype none

module layer_norm_top #(
  parameter int LANES    = 2,
  parameter int ROW_SIZE = 8
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [LANES*ln_fixed_pkg::IN_WIDTH-1:0]  in_data,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output logic [LANES*ln_fixed_pkg::OUT_WIDTH-1:0] out_data,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  import ln_fixed_pkg::*;

  localparam int ROW_BUFFER_DEPTH = 4 * ROW_SIZE / LANES;
  localparam int VAR_W            = sq_width() + $clog2(ROW_SIZE);

  elem_t [LANES-1:0]               in_lanes;
  elem_t [LANES-1:0]               x_data;
  diff_t [LANES-1:0]               diff_in;
  diff_t [LANES-1:0]               diff_out;
  logic [LANES-1:0][OUT_WIDTH-1:0] out_lanes;
  elem_t                           mean;
  logic [VAR_W-1:0]                var_data;
  logic [ISQRT_WIDTH-1:0]          root;
  logic mean_in_valid, mean_in_ready;
  logic row_in_valid, row_in_ready;
  logic x_valid, x_ready;
  logic mean_valid, mean_ready;
  logic diff_in_valid, diff_in_ready;
  logic diff_out_valid, diff_out_ready;
  logic var_valid, var_ready;
  logic root_valid, root_ready;

  for (genvar i = 0; i < LANES; i++) begin : g_pack
    assign in_lanes[i]                       = in_data[i*IN_WIDTH +: IN_WIDTH];
    assign out_data[i*OUT_WIDTH +: OUT_WIDTH] = out_lanes[i];
  end

  // A beat enters both branches in the same cycle or neither
  assign mean_in_valid = in_valid && row_in_ready;
  assign row_in_valid  = in_valid && mean_in_ready;
  assign in_ready      = mean_in_ready && row_in_ready;

  ln_mean_accum #(.LANES(LANES), .ROW_SIZE(ROW_SIZE)) u_mean (
    .clk(clk), .arst_n(arst_n),
    .in_data(in_lanes), .in_valid(mean_in_valid), .in_ready(mean_in_ready),
    .mean(mean), .mean_valid(mean_valid), .mean_ready(mean_ready)
  );

  ln_row_buffer #(
    .DATA_W(IN_WIDTH), .LANES(LANES), .ROW_BUFFER_DEPTH(ROW_BUFFER_DEPTH)
  ) row_buf (
    .clk(clk), .arst_n(arst_n),
    .wr_data(in_lanes), .wr_valid(row_in_valid), .wr_ready(row_in_ready),
    .rd_data(x_data), .rd_valid(x_valid), .rd_ready(x_ready)
  );

  ln_variance_unit #(.LANES(LANES), .ROW_SIZE(ROW_SIZE)) u_var (
    .clk(clk), .arst_n(arst_n),
    .x_data(x_data), .x_valid(x_valid), .x_ready(x_ready),
    .mean(mean), .mean_valid(mean_valid), .mean_ready(mean_ready),
    .diff_data(diff_in), .diff_valid(diff_in_valid), .diff_ready(diff_in_ready),
    .var_data(var_data), .var_valid(var_valid), .var_ready(var_ready)
  );

  ln_row_buffer #(
    .DATA_W(DIFF_WIDTH), .LANES(LANES), .ROW_BUFFER_DEPTH(ROW_BUFFER_DEPTH)
  ) diff_buf (
    .clk(clk), .arst_n(arst_n),
    .wr_data(diff_in), .wr_valid(diff_in_valid), .wr_ready(diff_in_ready),
    .rd_data(diff_out), .rd_valid(diff_out_valid), .rd_ready(diff_out_ready)
  );

  ln_isqrt_lut #(.ROW_SIZE(ROW_SIZE)) u_isqrt (
    .clk(clk), .arst_n(arst_n),
    .var_data(var_data), .var_valid(var_valid), .var_ready(var_ready),
    .root(root), .root_valid(root_valid), .root_ready(root_ready)
  );

  ln_normalize #(.LANES(LANES), .ROW_SIZE(ROW_SIZE)) u_norm (
    .clk(clk), .arst_n(arst_n),
    .root(root), .root_valid(root_valid), .root_ready(root_ready),
    .diff_data(diff_out), .diff_valid(diff_out_valid), .diff_ready(diff_out_ready),
    .out_data(out_lanes), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

`default_nettype wire

// ==== design/ln_normalize.sv ====
// Difference times inverse root with floor shift, saturation and output register
`timescale 1ns/1ps
`default_nettype none

module ln_normalize #(
  parameter int LANES    = 2,
  parameter int ROW_SIZE = 8
) (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  logic [ln_fixed_pkg::ISQRT_WIDTH-1:0]         root,
  input  logic                                         root_valid,
  output logic                                         root_ready,
  input  ln_fixed_pkg::diff_t [LANES-1:0]              diff_data,
  input  logic                                         diff_valid,
  output logic                                         diff_ready,
  output logic [LANES-1:0][ln_fixed_pkg::OUT_WIDTH-1:0] out_data,
  output logic                                         out_valid,
  input  logic                                         out_ready
);

  import ln_fixed_pkg::*;
  import ln_ctrl_pkg::*;

  localparam int BEATS      = ROW_SIZE / LANES;
  localparam int CNT_W      = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int PROD_W     = DIFF_WIDTH + ISQRT_WIDTH + 1;
  localparam int NORM_SHIFT = IN_FRAC + ISQRT_FRAC - OUT_FRAC;
  localparam int OUT_MAX    = 2 ** (OUT_WIDTH - 1) - 1;
  localparam int OUT_MIN    = -(2 ** (OUT_WIDTH - 1));

  norm_state_e                           state;
  logic [CNT_W-1:0]                      beat_cnt;
  logic [ISQRT_WIDTH-1:0]                root_q;
  logic signed [PROD_W-1:0]              prod [LANES];
  logic signed [PROD_W-1:0]              scaled [LANES];
  logic [LANES-1:0][OUT_WIDTH-1:0]       result;
  logic                                  diff_fire;

  assign root_ready = (state == WAIT_ROOT);
  assign diff_ready = (state == STREAM) && (!out_valid || out_ready);
  assign diff_fire  = diff_valid && diff_ready;

  // Root is unsigned, so it gets a zero sign bit before the product
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      prod[i]   = diff_data[i] * $signed({1'b0, root_q});
      scaled[i] = prod[i] >>> NORM_SHIFT;
      if (scaled[i] > OUT_MAX) begin
        result[i] = OUT_WIDTH'(OUT_MAX);
      end else if (scaled[i] < OUT_MIN) begin
        result[i] = OUT_WIDTH'(OUT_MIN);
      end else begin
        result[i] = scaled[i][OUT_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= WAIT_ROOT;
      beat_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      if (diff_fire) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      case (state)
        WAIT_ROOT: begin
          if (root_valid) begin
            state    <= STREAM;
            beat_cnt <= '0;
          end
        end
        STREAM: begin
          // Root released after the row's last beat
          if (diff_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == CNT_W'(BEATS - 1)) begin
              state <= WAIT_ROOT;
            end
          end
        end
        default: state <= WAIT_ROOT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (root_valid && root_ready) begin
      root_q <= root;
    end
    if (diff_fire) begin
      out_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== design/ln_isqrt_lut.sv ====
// Variance to index cast and registered inverse square root lookup
`timescale 1ns/1ps
`default_nettype none

module ln_isqrt_lut #(
  parameter int ROW_SIZE = 8
) (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  logic [ln_fixed_pkg::sq_width()+$clog2(ROW_SIZE)-1:0] var_data,
  input  logic                                                 var_valid,
  output logic                                                 var_ready,
  output logic [ln_fixed_pkg::ISQRT_WIDTH-1:0]                 root,
  output logic                                                 root_valid,
  input  logic                                                 root_ready
);

  import ln_fixed_pkg::*;

  localparam int VAR_W      = sq_width() + $clog2(ROW_SIZE);
  localparam int IDX_SHIFT  = 2 * IN_FRAC - ISQRT_FRAC;
  localparam int TABLE_SIZE = 2 ** ISQRT_WIDTH;

  logic [ISQRT_WIDTH-1:0] lut [TABLE_SIZE];
  logic [VAR_W-1:0]       var_floor;
  logic [ISQRT_WIDTH-1:0] idx;
  logic                   var_fire;

  // Table contents fixed at elaboration
  for (genvar v = 0; v < TABLE_SIZE; v++) begin : g_table
    assign lut[v] = isqrt_entry(v);
  end

  // Drop fraction bits, then saturate at the top index
  assign var_floor = var_data >> IDX_SHIFT;
  assign idx       = (var_floor > VAR_W'(TABLE_SIZE - 1)) ? '1 : var_floor[ISQRT_WIDTH-1:0];

  assign var_ready = !root_valid || root_ready;
  assign var_fire  = var_valid && var_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      root_valid <= 1'b0;
    end else if (var_fire) begin
      root_valid <= 1'b1;
    end else if (root_ready) begin
      root_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (var_fire) begin
      root <= lut[idx];
    end
  end

endmodule

`default_nettype wire

// ==== design/ln_variance_unit.sv ====
// Centred differences per lane and the row variance of their squares
`timescale 1ns/1ps
`default_nettype none

module ln_variance_unit #(
  parameter int LANES    = 2,
  parameter int ROW_SIZE = 8
) (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  ln_fixed_pkg::elem_t [LANES-1:0]                   x_data,
  input  logic                                              x_valid,
  output logic                                              x_ready,
  input  ln_fixed_pkg::elem_t                               mean,
  input  logic                                              mean_valid,
  output logic                                              mean_ready,
  output ln_fixed_pkg::diff_t [LANES-1:0]                   diff_data,
  output logic                                              diff_valid,
  input  logic                                              diff_ready,
  output logic [ln_fixed_pkg::sq_width()+$clog2(ROW_SIZE)-1:0] var_data,
  output logic                                              var_valid,
  input  logic                                              var_ready
);

  import ln_fixed_pkg::*;
  import ln_ctrl_pkg::*;

  localparam int BEATS = ROW_SIZE / LANES;
  localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int SHIFT = $clog2(ROW_SIZE);
  localparam int SQ_W  = sq_width();
  localparam int VAR_W = SQ_W + SHIFT;

  acc_state_e             state;
  logic [CNT_W-1:0]       beat_cnt;
  diff_t [LANES-1:0]      diff;
  logic signed [SQ_W-1:0] sq [LANES];
  logic [VAR_W-1:0]       sq_sum;
  logic [VAR_W-1:0]       acc;
  logic [VAR_W-1:0]       row_total;
  logic                   last_beat;
  logic                   fire;

  // Needs the mean, a free output slot and no pending variance
  assign x_ready    = mean_valid && (state != HOLD) && (!diff_valid || diff_ready);
  assign fire       = x_valid && x_ready;
  assign last_beat  = (beat_cnt == CNT_W'(BEATS - 1));
  assign mean_ready = fire && last_beat;
  assign var_valid  = (state == HOLD);

  always_comb begin
    sq_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      diff[i] = diff_t'(x_data[i]) - diff_t'(mean);
      sq[i]   = diff[i] * diff[i];
      sq_sum  = sq_sum + VAR_W'($unsigned(sq[i]));
    end
  end

  assign row_total = ((state == ACCUM) ? acc : '0) + sq_sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      beat_cnt   <= '0;
      diff_valid <= 1'b0;
    end else begin
      if (fire) begin
        diff_valid <= 1'b1;
      end else if (diff_ready) begin
        diff_valid <= 1'b0;
      end
      case (state)
        IDLE, ACCUM: begin
          if (fire && last_beat) begin
            state    <= HOLD;
            beat_cnt <= '0;
          end else if (fire) begin
            state    <= ACCUM;
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        HOLD: begin
          if (var_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Variance keeps 2*IN_FRAC fraction bits after the divide
  always_ff @(posedge clk) begin
    if (fire) begin
      diff_data <= diff;
      acc       <= row_total;
      if (last_beat) begin
        var_data <= row_total >> SHIFT;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/ln_mean_accum.sv ====
// Row mean accumulator with lane summing and arithmetic-shift division
`timescale 1ns/1ps
`default_nettype none

module ln_mean_accum #(
  parameter int LANES    = 2,
  parameter int ROW_SIZE = 8
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  ln_fixed_pkg::elem_t [LANES-1:0]  in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output ln_fixed_pkg::elem_t              mean,
  output logic                             mean_valid,
  input  logic                             mean_ready
);

  import ln_fixed_pkg::*;
  import ln_ctrl_pkg::*;

  localparam int BEATS = ROW_SIZE / LANES;
  localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int SHIFT = $clog2(ROW_SIZE);
  localparam int SUM_W = IN_WIDTH + SHIFT;

  acc_state_e              state;
  logic [CNT_W-1:0]        beat_cnt;
  logic signed [SUM_W-1:0] beat_sum;
  logic signed [SUM_W-1:0] acc;
  logic signed [SUM_W-1:0] row_total;
  logic                    last_beat;
  logic                    fire;

  assign in_ready   = (state != HOLD);
  assign mean_valid = (state == HOLD);
  assign fire       = in_valid && in_ready;
  assign last_beat  = (beat_cnt == CNT_W'(BEATS - 1));

  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      beat_sum = beat_sum + SUM_W'(in_data[i]);
    end
  end

  // First beat of a row starts from zero
  assign row_total = ((state == ACCUM) ? acc : '0) + beat_sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE, ACCUM: begin
          if (fire && last_beat) begin
            state    <= HOLD;
            beat_cnt <= '0;
          end else if (fire) begin
            state    <= ACCUM;
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        HOLD: begin
          if (mean_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift rounds toward minus infinity
  always_ff @(posedge clk) begin
    if (fire) begin
      acc <= row_total;
      if (last_beat) begin
        mean <= elem_t'(row_total >>> SHIFT);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/ln_row_buffer.sv ====
// Multi-lane circular FIFO holding row beats for later stages
`timescale 1ns/1ps
`default_nettype none

module ln_row_buffer #(
  parameter int DATA_W           = 8,
  parameter int LANES            = 2,
  parameter int ROW_BUFFER_DEPTH = 16
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [LANES-1:0][DATA_W-1:0]  wr_data,
  input  logic                          wr_valid,
  output logic                          wr_ready,
  output logic [LANES-1:0][DATA_W-1:0]  rd_data,
  output logic                          rd_valid,
  input  logic                          rd_ready
);

  localparam int PTR_W = (ROW_BUFFER_DEPTH > 1) ? $clog2(ROW_BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ROW_BUFFER_DEPTH + 1);

  logic [LANES-1:0][DATA_W-1:0] mem [ROW_BUFFER_DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             count;
  logic                         wr_fire;
  logic                         rd_fire;

  // Wraps at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(ROW_BUFFER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_ready = (count != CNT_W'(ROW_BUFFER_DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous read and write leaves the fill level unchanged
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/ln_ctrl_pkg.sv ====
// State encodings for the accumulating and normalizing controllers
`default_nettype none

package ln_ctrl_pkg;

  // Mean and variance accumulators
  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    HOLD
  } acc_state_e;

  // Normalizer holds one root per row
  typedef enum logic {
    WAIT_ROOT,
    STREAM
  } norm_state_e;

endpackage

`default_nettype wire

// ==== design/ln_fixed_pkg.sv ====
// Fixed-point formats, derived widths, element types and the inverse-root table rule
`default_nettype none

package ln_fixed_pkg;

  // Signed input elements
  localparam int IN_WIDTH = 8;
  localparam int IN_FRAC  = 4;

  // Signed output elements
  localparam int OUT_WIDTH = 8;
  localparam int OUT_FRAC  = 4;

  // Unsigned inverse root, also the format of the table index
  localparam int ISQRT_WIDTH = 8;
  localparam int ISQRT_FRAC  = 4;

  // Centred difference, same fraction as the input
  localparam int DIFF_WIDTH = IN_WIDTH + 1;

  typedef logic signed [IN_WIDTH-1:0]   elem_t;
  typedef logic signed [DIFF_WIDTH-1:0] diff_t;

  // Square of a difference carries 2*IN_FRAC fraction bits
  function automatic int sq_width();
    return 2 * DIFF_WIDTH;
  endfunction

  // floor(16*sqrt(16/v)) equals floor(sqrt(4096/v)) on the integer quotient
  function automatic logic [ISQRT_WIDTH-1:0] isqrt_entry(int unsigned v);
    int unsigned n;
    int unsigned r;
    if (v == 0) begin
      return '1;
    end
    n = (2 ** (3 * ISQRT_FRAC)) / v;
    r = 0;
    while ((r + 1) * (r + 1) <= n) begin
      r++;
    end
    if (r > 2 ** ISQRT_WIDTH - 1) begin
      return '1;
    end
    return ISQRT_WIDTH'(r);
  endfunction

endpackage

`default_nettype wire
